// ==== rtl/megarom_pkg.sv ====
// ==============================
// Megarom controller constants
// Register map, flag bits, unlock
// key, reset defaults and fixed
// addresses of the cartridge
// ==============================

package megarom_pkg;

    // Unlock key bytes for offsets 0 to 3
    localparam logic [7:0] key_0 = 8'hAB;
    localparam logic [7:0] key_1 = 8'hCD;
    localparam logic [7:0] key_2 = 8'h98;
    localparam logic [7:0] key_3 = 8'h76;

    // Number of bank registers
    localparam int bank_count = 4;

    // Offsets inside the 32 byte window
    localparam logic [4:0] reg_key_0       = 5'h00;
    localparam logic [4:0] reg_key_1       = 5'h01;
    localparam logic [4:0] reg_key_2       = 5'h02;
    localparam logic [4:0] reg_key_3       = 5'h03;
    localparam logic [4:0] reg_flags       = 5'h0C;
    localparam logic [4:0] reg_mask_val    = 5'h0D;
    localparam logic [4:0] reg_mask_addr_l = 5'h0E;
    localparam logic [4:0] reg_mask_addr_h = 5'h0F;

    // Per bank offsets with a stride of 4 from 10h
    // Fourth byte of each group is spare
    localparam logic [4:0] reg_bank_addr_l [bank_count] = '{5'h10, 5'h14, 5'h18, 5'h1C};
    localparam logic [4:0] reg_bank_addr_h [bank_count] = '{5'h11, 5'h15, 5'h19, 5'h1D};
    localparam logic [4:0] reg_bank_init   [bank_count] = '{5'h12, 5'h16, 5'h1A, 5'h1E};

    // Bit positions in the flags register
    localparam logic [2:0] flag_write_protect = 3'd0;
    localparam logic [2:0] flag_bank_16k      = 3'd1;
    localparam logic [2:0] flag_cs1_mask      = 3'd2;
    localparam logic [2:0] flag_cs2_mask      = 3'd3;
    localparam logic [2:0] flag_scc           = 3'd4;
    // Keeps the enable bit across a bus reset
    localparam logic [2:0] flag_enable_cont   = 3'd6;
    localparam logic [2:0] flag_enable        = 3'd7;

    // Reset defaults
    // No bank register hit until configured
    localparam logic [15:0] default_bank_addr = 16'hFFFF;
    localparam logic [15:0] default_addr_mask = 16'h0000;
    localparam logic [7:0]  default_data_mask = 8'h00;
    localparam logic [7:0]  default_init      = 8'h00;
    // Write protect, 16k, both masks and scc set
    // Enable and continuous clear
    localparam logic [7:0]  default_flags     = 8'b0001_1111;

    // Config window base lies outside both cartridge windows
    localparam logic [15:0] config_base = 16'h3FE0;

    // Start of cartridge image in flat memory
    localparam logic [23:0] mem_top = 24'h100000;

endpackage

// ==== rtl/megarom_config.sv ====
// ==============================
// Megarom configuration block
// Key protected 32 byte register
// window, bus write edge strobe
// and decoded mapper settings
// ==============================

`timescale 1ns/1ps

module megarom_config (
    input  logic        CLK,
    input  logic        RESET_n,
    input  logic        bus_reset_n,
    input  logic        sltsl_n,
    input  logic        merq_n,
    input  logic        rd_n,
    input  logic        wr_n,
    input  logic [15:0] addr,
    input  logic [7:0]  din,
    output logic [7:0]  dout,
    output logic        busdir_n,
    output logic        wr_stb,
    output logic        scc_ena_n,
    output logic [15:0] bank_addr [megarom_pkg::bank_count],
    output logic [15:0] bank_addr_mask,
    output logic [7:0]  bank_data_mask,
    output logic [7:0]  bank_init [megarom_pkg::bank_count],
    output logic        bank_16k,
    output logic        write_protect,
    output logic        cs1_off,
    output logic        cs2_off
);
    import megarom_pkg::*;

    // Register window
    logic [7:0] cfg_reg [32];
    logic [7:0] flags;

    // Bus qualifiers
    logic rd_act;
    logic wr_act;
    logic wr_act_q;

    // Decode
    logic unlocked;
    logic in_window;
    logic in_key_window;
    logic wr_sel;

    // Power-on value of one register byte
    function automatic logic [7:0] reset_value(input logic [4:0] offset);
        logic [7:0] value;
        value = 8'h00;
        case (offset)
            // Inverted key so the block starts locked
            reg_key_0:       value = ~key_0;
            reg_key_1:       value = ~key_1;
            reg_key_2:       value = ~key_2;
            reg_key_3:       value = ~key_3;
            reg_flags:       value = default_flags;
            reg_mask_val:    value = default_data_mask;
            reg_mask_addr_l: value = default_addr_mask[7:0];
            reg_mask_addr_h: value = default_addr_mask[15:8];
            default:         value = 8'h00;
        endcase
        for (int i = 0; i < bank_count; i++) begin
            if (offset == reg_bank_addr_l[i])
                value = default_bank_addr[7:0];
            if (offset == reg_bank_addr_h[i])
                value = default_bank_addr[15:8];
            if (offset == reg_bank_init[i])
                value = default_init;
        end
        return value;
    endfunction

    assign rd_act = !sltsl_n && !merq_n && !rd_n;
    assign wr_act = !sltsl_n && !merq_n && !wr_n;

    // Previous write state
    // Forced active during bus reset so no strobe fires there
    // or for a write spanning its release
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n)
            wr_act_q <= 1'b1;
        else if (!bus_reset_n)
            wr_act_q <= 1'b1;
        else
            wr_act_q <= wr_act;
    end

    // First cycle of a write
    assign wr_stb = wr_act && !wr_act_q;

    // Unlocked only with all four key bytes in place
    assign unlocked = (cfg_reg[reg_key_0] == key_0) &&
                      (cfg_reg[reg_key_1] == key_1) &&
                      (cfg_reg[reg_key_2] == key_2) &&
                      (cfg_reg[reg_key_3] == key_3);

    assign in_window     = addr[15:5] == config_base[15:5];
    assign in_key_window = addr[15:2] == config_base[15:2];
    // Locked block accepts key bytes only
    assign wr_sel = unlocked ? in_window : in_key_window;

    // Read back one cycle behind the bus
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            busdir_n <= 1'b1;
            dout     <= 8'h00;
        end else if (!bus_reset_n || !rd_act || !unlocked || !in_window) begin
            busdir_n <= 1'b1;
            dout     <= 8'h00;
        end else begin
            busdir_n <= 1'b0;
            dout     <= cfg_reg[addr[4:0]];
        end
    end

    // Register writes
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            for (int i = 0; i < 32; i++)
                cfg_reg[i] <= reset_value(5'(i));
        end else if (!bus_reset_n) begin
            // Reset button turns the cartridge off unless continuous
            if (!cfg_reg[reg_flags][flag_enable_cont])
                cfg_reg[reg_flags][flag_enable] <= 1'b0;
        end else if (wr_stb && wr_sel) begin
            cfg_reg[addr[4:0]] <= din;
        end
    end

    // Decoded settings
    assign flags = cfg_reg[reg_flags];

    always_comb begin
        for (int i = 0; i < bank_count; i++) begin
            bank_addr[i] = {cfg_reg[reg_bank_addr_h[i]], cfg_reg[reg_bank_addr_l[i]]};
            bank_init[i] = cfg_reg[reg_bank_init[i]];
        end
    end

    assign bank_addr_mask = {cfg_reg[reg_mask_addr_h], cfg_reg[reg_mask_addr_l]};
    assign bank_data_mask = cfg_reg[reg_mask_val];
    assign bank_16k       = flags[flag_bank_16k];
    assign write_protect  = flags[flag_write_protect];
    // Window off when masked or cartridge disabled
    assign cs1_off        = flags[flag_cs1_mask] || !flags[flag_enable];
    assign cs2_off        = flags[flag_cs2_mask] || !flags[flag_enable];
    // Sound chip enable level is the flag itself
    assign scc_ena_n      = flags[flag_scc];

endmodule

// ==== rtl/megarom_bank_regs.sv ====
// ==============================
// Megarom bank register file
// Snoops CPU writes and keeps
// the four bank numbers
// ==============================

`timescale 1ns/1ps

module megarom_bank_regs (
    input  logic        CLK,
    input  logic        RESET_n,
    input  logic        bus_reset_n,
    input  logic        wr_stb,
    input  logic [15:0] addr,
    input  logic [7:0]  din,
    input  logic [15:0] bank_addr [megarom_pkg::bank_count],
    input  logic [15:0] bank_addr_mask,
    input  logic [7:0]  bank_data_mask,
    input  logic [7:0]  bank_init [megarom_pkg::bank_count],
    output logic [7:0]  bank [megarom_pkg::bank_count]
);
    import megarom_pkg::*;

    // Address compare per bank
    logic [bank_count-1:0] match;
    // One-hot lowest matching bank
    logic [bank_count-1:0] hit;
    logic                  found;
    // Value stored on a hit
    logic [7:0]            wr_val;

    // Masked address bits are don't care
    always_comb begin
        for (int i = 0; i < bank_count; i++)
            match[i] = ((addr ^ bank_addr[i]) & ~bank_addr_mask) == 16'h0000;
    end

    // Priority to bank 0
    always_comb begin
        hit   = '0;
        found = 1'b0;
        for (int i = 0; i < bank_count; i++) begin
            if (match[i] && !found) begin
                hit[i] = 1'b1;
                found  = 1'b1;
            end
        end
    end

    // Data mask clears unused bank bits
    assign wr_val = din & ~bank_data_mask;

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            // Init registers hold their defaults after power-on
            for (int i = 0; i < bank_count; i++)
                bank[i] <= default_init;
        end else if (!bus_reset_n) begin
            // Bus reset reloads the configured init values
            for (int i = 0; i < bank_count; i++)
                bank[i] <= bank_init[i];
        end else if (wr_stb) begin
            for (int i = 0; i < bank_count; i++) begin
                if (hit[i])
                    bank[i] <= wr_val;
            end
        end
    end

endmodule

// ==== rtl/megarom_mapper.sv ====
// ==============================
// Megarom address mapper
// Slot accesses to registered
// flat memory address and strobes
// ==============================

`timescale 1ns/1ps

module megarom_mapper (
    input  logic        CLK,
    input  logic        RESET_n,
    input  logic        bus_reset_n,
    input  logic        sltsl_n,
    input  logic        merq_n,
    input  logic        rd_n,
    input  logic        wr_stb,
    input  logic [15:0] addr,
    input  logic [7:0]  bank [megarom_pkg::bank_count],
    input  logic        bank_16k,
    input  logic        write_protect,
    input  logic        cs1_off,
    input  logic        cs2_off,
    output logic [23:0] mem_addr,
    output logic        mem_rd,
    output logic        mem_wr
);
    import megarom_pkg::*;

    logic        rd_act;
    // 4000-7FFF and 8000-BFFF
    logic        win1;
    logic        win2;
    logic        win_on;
    logic        wr_ok;
    // 8k quarter index over 4000-BFFF
    logic [1:0]  quarter;
    logic [7:0]  bank_16;
    logic [23:0] offset;

    assign rd_act = !sltsl_n && !merq_n && !rd_n;

    assign win1   = addr[15:14] == 2'b01;
    assign win2   = addr[15:14] == 2'b10;
    assign win_on = (win1 && !cs1_off) || (win2 && !cs2_off);
    assign wr_ok  = wr_stb && win_on && !write_protect;

    // 010x -> 0, 011x -> 1, 100x -> 2, 101x -> 3
    assign quarter = {addr[15], addr[13]};
    // Bank 0 for window 1, bank 1 for window 2
    assign bank_16 = addr[15] ? bank[1] : bank[0];

    // Bank times page size plus page offset
    always_comb begin
        if (bank_16k)
            offset = {2'b00, bank_16, addr[13:0]};
        else
            offset = {3'b000, bank[quarter], addr[12:0]};
    end

    // Strobes stay quiet during bus reset
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            mem_rd <= 1'b0;
            mem_wr <= 1'b0;
        end else if (!bus_reset_n) begin
            mem_rd <= 1'b0;
            mem_wr <= 1'b0;
        end else begin
            mem_rd <= rd_act && win_on;
            // Follows the write strobe by one cycle
            mem_wr <= wr_ok;
        end
    end

    // Address held between accesses
    // A masked window leaves it unchanged
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n)
            mem_addr <= 24'h000000;
        else if ((rd_act && win_on) || wr_ok)
            mem_addr <= mem_top + offset;
    end

endmodule

// ==== rtl/megarom_cart.sv ====
// ==============================
// Megarom cartridge top
// Config block, bank registers
// and mapper on the slot bus
// ==============================

`timescale 1ns/1ps

module megarom_cart (
    input  logic        CLK,
    input  logic        RESET_n,
    // Slot bus
    input  logic        bus_reset_n,
    input  logic        sltsl_n,
    input  logic        merq_n,
    input  logic        rd_n,
    input  logic        wr_n,
    input  logic [15:0] addr,
    input  logic [7:0]  din,
    output logic [7:0]  dout,
    output logic        busdir_n,
    output logic        scc_ena_n,
    // Memory side
    output logic [23:0] mem_addr,
    output logic        mem_rd,
    output logic        mem_wr
);
    import megarom_pkg::*;

    // Write edge from the config block
    logic        wr_stb;

    // Decoded configuration
    logic [15:0] bank_addr [bank_count];
    logic [15:0] bank_addr_mask;
    logic [7:0]  bank_data_mask;
    logic [7:0]  bank_init [bank_count];
    logic        bank_16k;
    logic        write_protect;
    logic        cs1_off;
    logic        cs2_off;

    // Current bank numbers
    logic [7:0]  bank [bank_count];

    megarom_config u_config (
        .CLK            (CLK),
        .RESET_n        (RESET_n),
        .bus_reset_n    (bus_reset_n),
        .sltsl_n        (sltsl_n),
        .merq_n         (merq_n),
        .rd_n           (rd_n),
        .wr_n           (wr_n),
        .addr           (addr),
        .din            (din),
        .dout           (dout),
        .busdir_n       (busdir_n),
        .wr_stb         (wr_stb),
        .scc_ena_n      (scc_ena_n),
        .bank_addr      (bank_addr),
        .bank_addr_mask (bank_addr_mask),
        .bank_data_mask (bank_data_mask),
        .bank_init      (bank_init),
        .bank_16k       (bank_16k),
        .write_protect  (write_protect),
        .cs1_off        (cs1_off),
        .cs2_off        (cs2_off)
    );

    megarom_bank_regs u_bank_regs (
        .CLK            (CLK),
        .RESET_n        (RESET_n),
        .bus_reset_n    (bus_reset_n),
        .wr_stb         (wr_stb),
        .addr           (addr),
        .din            (din),
        .bank_addr      (bank_addr),
        .bank_addr_mask (bank_addr_mask),
        .bank_data_mask (bank_data_mask),
        .bank_init      (bank_init),
        .bank           (bank)
    );

    megarom_mapper u_mapper (
        .CLK            (CLK),
        .RESET_n        (RESET_n),
        .bus_reset_n    (bus_reset_n),
        .sltsl_n        (sltsl_n),
        .merq_n         (merq_n),
        .rd_n           (rd_n),
        .wr_stb         (wr_stb),
        .addr           (addr),
        .bank           (bank),
        .bank_16k       (bank_16k),
        .write_protect  (write_protect),
        .cs1_off        (cs1_off),
        .cs2_off        (cs2_off),
        .mem_addr       (mem_addr),
        .mem_rd         (mem_rd),
        .mem_wr         (mem_wr)
    );

endmodule

// ==== test/megarom_chk.sv ====
// ==============================
// Megarom bus checker
// Assertions on read direction
// and memory strobes
// ==============================

`timescale 1ns/1ps

module megarom_chk (
    input logic CLK,
    input logic RESET_n,
    input logic rd_n,
    input logic busdir_n,
    input logic mem_rd,
    input logic mem_wr
);

    // Write strobe is a single cycle
    wr_pulse: assert property (@(posedge CLK) disable iff (!RESET_n) mem_wr |=> !mem_wr)
        else $error("mem_wr stayed high for more than one cycle");

    // Bus released one cycle after the read ends
    dir_idle: assert property (@(posedge CLK) disable iff (!RESET_n) rd_n |=> busdir_n)
        else $error("busdir_n low without a read in the previous cycle");

    // Never read and write at once
    strobe_excl: assert property (@(posedge CLK) disable iff (!RESET_n) !(mem_rd && mem_wr))
        else $error("mem_rd and mem_wr high in the same cycle");

endmodule

bind megarom_cart megarom_chk u_chk (
    .CLK      (CLK),
    .RESET_n  (RESET_n),
    .rd_n     (rd_n),
    .busdir_n (busdir_n),
    .mem_rd   (mem_rd),
    .mem_wr   (mem_wr)
);

// ==== test/megarom_tb.sv ====
// ==============================
// Megarom cartridge testbench
// Replays slot bus operations
// from a vector file and checks
// bus and memory side responses
// ==============================

`timescale 1ns/1ps

module megarom_tb;

    logic        CLK = 1'b0;
    logic        RESET_n;
    // Slot bus
    logic        bus_reset_n;
    logic        sltsl_n;
    logic        merq_n;
    logic        rd_n;
    logic        wr_n;
    logic [15:0] addr;
    logic [7:0]  din;
    logic [7:0]  dout;
    logic        busdir_n;
    logic        scc_ena_n;
    // Memory side
    logic [23:0] mem_addr;
    logic        mem_rd;
    logic        mem_wr;

    // Vector table with one entry per operation
    logic [7:0]  op_list [$];
    logic [15:0] addr_list [$];
    logic [7:0]  data_list [$];
    logic [23:0] expect_list [$];
    logic        loaded = 1'b0;

    megarom_cart u_megarom_cart (
        .CLK         (CLK),
        .RESET_n     (RESET_n),
        .bus_reset_n (bus_reset_n),
        .sltsl_n     (sltsl_n),
        .merq_n      (merq_n),
        .rd_n        (rd_n),
        .wr_n        (wr_n),
        .addr        (addr),
        .din         (din),
        .dout        (dout),
        .busdir_n    (busdir_n),
        .scc_ena_n   (scc_ena_n),
        .mem_addr    (mem_addr),
        .mem_rd      (mem_rd),
        .mem_wr      (mem_wr)
    );

    // 8 ns period
    always #4 CLK = ~CLK;

    task automatic abort(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "Run stopped on error");
    endtask

    task automatic check(input string name, input logic [23:0] expected,
                         input logic [23:0] actual);
        if (actual !== expected)
            abort($sformatf("FAILED at %0d ns: %s expected %h got %h",
                            $time, name, expected, actual));
    endtask

    // All strobes inactive
    task automatic bus_idle();
        bus_reset_n = 1'b1;
        sltsl_n     = 1'b1;
        merq_n      = 1'b1;
        rd_n        = 1'b1;
        wr_n        = 1'b1;
        addr        = 16'h0000;
        din         = 8'h00;
    endtask

    task automatic load_vectors();
        int          fd;
        int          fields;
        string       line;
        logic [7:0]  op;
        logic [15:0] a;
        logic [7:0]  d;
        logic [23:0] e;
        fd = $fopen("test/megarom_vectors.txt", "r");
        if (fd == 0)
            abort("Cannot open the vector file test/megarom_vectors.txt");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // Comment and blank lines skipped
            if (line.len() > 1 && line.getc(0) != "#") begin
                fields = $sscanf(line, "%c %h %h %h", op, a, d, e);
                if (fields != 4)
                    abort({"Malformed line in the vector file: ", line});
                op_list.push_back(op);
                addr_list.push_back(a);
                data_list.push_back(d);
                expect_list.push_back(e);
            end
        end
        $fclose(fd);
        loaded = 1'b1;
    endtask

    // One operation starts and ends on a falling edge
    task automatic apply_op(input logic [7:0] op, input logic [15:0] a,
                            input logic [7:0] d, input logic [23:0] e);
        logic pulse;
        pulse = 1'b0;
        addr  = a;
        din   = d;
        case (op)
            "W", "P": begin
                sltsl_n = 1'b0;
                merq_n  = 1'b0;
                wr_n    = 1'b0;
            end
            "R", "M": begin
                sltsl_n = 1'b0;
                merq_n  = 1'b0;
                rd_n    = 1'b0;
            end
            "B": bus_reset_n = 1'b0;
            default: abort($sformatf("Unknown operation %c in the vector file", op));
        endcase
        // Three bus cycles with the write pulse caught on any of them
        repeat (3) begin
            @(negedge CLK);
            pulse = pulse | mem_wr;
        end
        case (op)
            "R": begin
                check("dout", e, 24'(dout));
                check("busdir_n", 24'(d[0]), 24'(busdir_n));
                check("scc_ena_n", 24'(d[1]), 24'(scc_ena_n));
            end
            "M": begin
                check("mem_addr", e, mem_addr);
                check("mem_rd", 24'(d[0]), 24'(mem_rd));
            end
            "P": check("mem_wr", e, 24'(pulse));
            default: ;
        endcase
        bus_idle();
    endtask

    initial begin
        int gap;
        bus_idle();
        RESET_n = 1'b0;
        void'($urandom(35));
        load_vectors();
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        RESET_n = 1'b1;
        // One idle clock clears the write edge history
        @(negedge CLK);
        foreach (op_list[i]) begin
            apply_op(op_list[i], addr_list[i], data_list[i], expect_list[i]);
            gap = 1 + int'($urandom % 3);
            repeat (gap) @(negedge CLK);
        end
        $display("Simulation passed");
        $finish;
    end

    // Watchdog budget scales with the vector count
    initial begin
        wait (loaded);
        repeat (op_list.size() * 10 + 100) @(posedge CLK);
        abort("Timeout: the vector run did not finish in the allowed time");
    end

endmodule

// ==== test/megarom_vectors.txt ====
# op addr data expected, all hex; W write, R register read, M memory read, P memory write, B bus reset
# R data: bit1 scc_ena_n, bit0 busdir_n; M data: mem_rd; R expects dout, M mem_addr, P mem_wr pulse
R 3FEC 03 000000
W 3FEC 00 000000
W 3FE0 AB 000000
W 3FE1 CD 000000
W 3FE2 98 000000
W 3FE3 76 000000
R 3FEC 02 00001F
W 3FF1 50 000000
W 3FF5 70 000000
W 3FF9 90 000000
W 3FFD B0 000000
W 3FEF 0F 000000
W 3FF2 03 000000
W 3FF6 04 000000
R 3FF5 02 000070
R 3FEF 02 00000F
W 3FEC 82 000000
R 3FEC 00 000082
M 4123 01 100123
W 50FF 07 000000
M 4123 01 11C123
W 7FFF 09 000000
M 8456 01 124456
W 3FED 0F 000000
W 50FF 35 000000
M 4001 01 1C0001
W 3FED 00 000000
W 3FEC 80 000000
W 90FF 02 000000
W B0FF 0A 000000
M 4010 01 160010
M 6020 01 112020
M 8030 01 104030
M A040 01 114040
P 4100 00 000001
W 3FEC 81 000000
P 4100 00 000000
W 3FEC 84 000000
P 4200 00 000000
M 4300 00 160100
B 0000 00 000000
M 8030 00 160100
W 3FEC 80 000000
M 4010 01 106010
W 3FEC C2 000000
B 0000 00 000000
M 4123 01 10C123
M 8456 01 110456

// ==== sources.f ====
rtl/megarom_pkg.sv
rtl/megarom_config.sv
rtl/megarom_bank_regs.sv
rtl/megarom_mapper.sv
rtl/megarom_cart.sv
test/megarom_chk.sv
test/megarom_tb.sv

// ==== Makefile ====
# Verilator build and run of the megarom testbench

VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = megarom_tb
FILELIST  = sources.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
